// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = execute_stage_tb
FILELIST = execute_stage.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== execute_stage.f ====
logic/exec_pkg.sv
logic/operand_forward.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/mult_unit.sv
logic/cdb_arbiter.sv
logic/execute_stage.sv
verif/execute_stage_chk.sv
verif/execute_stage_tb.sv

// ==== logic/alu_unit.sv ====
module alu_unit import exec_pkg::*; (
    input  issue_t     issue,
    input  operands_t  operands,
    output fu_result_t result
);

    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu_out;
    logic [4:0]      shamt;

    // ==================================================
    // Operand selection
    // ==================================================

    always_comb begin
        case (issue.opa_sel)
            opa_rs1:  opa = operands.src1;
            opa_pc:   opa = issue.pc;
            opa_npc:  opa = issue.pc + xlen'(4);
            default:  opa = '0;
        endcase
        opb = issue.opb_is_imm ? issue.imm : operands.src2;
    end

    // Shift amount from low bits of B
    assign shamt = opb[4:0];

    // ==================================================
    // Integer ALU
    // ==================================================

    always_comb begin
        case (issue.func.alu)
            alu_add:  alu_out = opa + opb;
            alu_sub:  alu_out = opa - opb;
            alu_and:  alu_out = opa & opb;
            alu_or:   alu_out = opa | opb;
            alu_xor:  alu_out = opa ^ opb;
            alu_slt:  alu_out = ($signed(opa) < $signed(opb)) ? xlen'(1) : '0;
            alu_sltu: alu_out = (opa < opb) ? xlen'(1) : '0;
            alu_sll:  alu_out = opa << shamt;
            alu_srl:  alu_out = opa >> shamt;
            alu_sra:  alu_out = $signed(opa) >>> shamt;
            // Unused codes
            default:  alu_out = '0;
        endcase
    end

    // Offer to the arbiter, no branch info
    always_comb begin
        result            = '0;
        result.valid      = issue.valid;
        result.write      = issue.dest_tag != '0;
        result.tag        = issue.dest_tag;
        result.data       = alu_out;
        result.rob_idx    = issue.rob_idx;
    end

endmodule

// ==== logic/branch_unit.sv ====
module branch_unit import exec_pkg::*; (
    input  issue_t     issue,
    input  operands_t  operands,
    output fu_result_t result
);

    logic            taken;
    logic            is_link;
    logic [xlen-1:0] target;

    // Branch condition
    always_comb begin
        case (issue.func.br)
            br_beq:  taken = operands.src1 == operands.src2;
            br_bne:  taken = operands.src1 != operands.src2;
            br_blt:  taken = $signed(operands.src1) < $signed(operands.src2);
            br_bge:  taken = $signed(operands.src1) >= $signed(operands.src2);
            br_bltu: taken = operands.src1 < operands.src2;
            br_bgeu: taken = operands.src1 >= operands.src2;
            // Jumps always redirect
            br_jal:  taken = 1'b1;
            br_jalr: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_link = (issue.func.br == br_jal) || (issue.func.br == br_jalr);

    // Target address
    always_comb begin
        if (issue.func.br == br_jalr) begin
            // Register-relative, bit 0 cleared
            target = (operands.src1 + issue.imm) & ~xlen'(1);
        end else begin
            target = issue.pc + issue.imm;
        end
    end

    // Offer, link value only written by jumps
    always_comb begin
        result            = '0;
        result.valid      = issue.valid;
        result.write      = is_link && (issue.dest_tag != '0);
        result.tag        = issue.dest_tag;
        result.data       = issue.pc + xlen'(4);
        result.rob_idx    = issue.rob_idx;
        result.is_branch  = 1'b1;
        result.taken      = taken;
        result.target     = target;
        result.mispredict = taken != issue.pred_taken;
    end

endmodule

// ==== logic/cdb_arbiter.sv ====
module cdb_arbiter import exec_pkg::*; (
    input  fu_result_t alu_res,
    input  fu_result_t br_res,
    input  fu_result_t mul_res,
    output logic       alu_grant,
    output logic       br_grant,
    output logic       mul_grant,
    output logic       alu_hold,
    output logic       br_hold,
    output cdb_entry_t cdb_out,
    output complete_t  complete
);

    fu_result_t win;

    // ==================================================
    // Fixed priority: mult, branch, ALU
    // ==================================================

    assign mul_grant = mul_res.valid;
    assign br_grant  = br_res.valid & ~mul_res.valid;
    assign alu_grant = alu_res.valid & ~mul_res.valid & ~br_res.valid;

    // Valid offer but lost
    assign alu_hold = alu_res.valid & ~alu_grant;
    assign br_hold  = br_res.valid & ~br_grant;

    // Winner mux, all zero when idle
    always_comb begin
        if (mul_grant) begin
            win = mul_res;
        end else if (br_grant) begin
            win = br_res;
        end else if (alu_grant) begin
            win = alu_res;
        end else begin
            win = '0;
        end
    end

    // Broadcast only for a register write
    always_comb begin
        cdb_out.valid = win.valid & win.write;
        cdb_out.tag   = win.tag;
        cdb_out.data  = win.data;
    end

    // Completion to the ROB
    always_comb begin
        complete.valid        = win.valid;
        complete.rob_idx      = win.rob_idx;
        complete.branch_valid = win.is_branch;
        complete.taken        = win.taken;
        complete.target       = win.target;
        complete.mispredict   = win.mispredict;
    end

endmodule

// ==== logic/exec_pkg.sv ====
package exec_pkg;

    // ==================================================
    // Widths
    // ==================================================

    localparam int xlen       = 32;
    // Tag 0 is the "no destination" register
    localparam int tag_width  = 6;
    localparam int rob_width  = 5;
    localparam int func_width = 4;

    // ==================================================
    // Function codes
    // ==================================================

    typedef enum logic [func_width-1:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_func_e;

    typedef enum logic [func_width-1:0] {
        br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jal, br_jalr
    } br_func_e;

    typedef enum logic [func_width-1:0] {
        mul_mul, mul_mulh, mul_mulhsu, mul_mulhu
    } mul_func_e;

    // One function word, read per lane type
    typedef union packed {
        alu_func_e alu;
        br_func_e  br;
        mul_func_e mul;
    } op_func_u;

    typedef enum logic [1:0] {
        opa_rs1, opa_pc, opa_npc, opa_zero
    } opa_sel_e;

    // ==================================================
    // Bus and lane packets
    // ==================================================

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        logic [xlen-1:0]      data;
    } cdb_entry_t;

    typedef struct packed {
        logic                 valid;
        op_func_u             func;
        opa_sel_e             opa_sel;
        logic                 opb_is_imm;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      imm;
        logic [tag_width-1:0] src1_tag;
        logic [tag_width-1:0] src2_tag;
        logic [tag_width-1:0] dest_tag;
        logic [rob_width-1:0] rob_idx;
        logic                 pred_taken;
    } issue_t;

    typedef struct packed {
        logic                 en1;
        logic [tag_width-1:0] tag1;
        logic                 en2;
        logic [tag_width-1:0] tag2;
    } prf_req_t;

    typedef struct packed {
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
    } operands_t;

    // Offer from a unit to the result bus arbiter
    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [tag_width-1:0] tag;
        logic [xlen-1:0]      data;
        logic [rob_width-1:0] rob_idx;
        logic                 is_branch;
        logic                 taken;
        logic [xlen-1:0]      target;
        logic                 mispredict;
    } fu_result_t;

    typedef struct packed {
        logic                 valid;
        logic [rob_width-1:0] rob_idx;
        logic                 branch_valid;
        logic                 taken;
        logic [xlen-1:0]      target;
        logic                 mispredict;
    } complete_t;

endpackage

// ==== logic/execute_stage.sv ====
module execute_stage import exec_pkg::*; #(
    parameter int cdb_lanes  = 2,
    parameter int mul_stages = 3
) (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       mispredict,
    input  issue_t                     alu_issue,
    input  issue_t                     br_issue,
    input  issue_t                     mul_issue,
    input  cdb_entry_t [cdb_lanes-1:0] cdb_in,
    output prf_req_t                   alu_prf_req,
    output prf_req_t                   br_prf_req,
    output prf_req_t                   mul_prf_req,
    input  operands_t                  alu_prf_data,
    input  operands_t                  br_prf_data,
    input  operands_t                  mul_prf_data,
    output cdb_entry_t                 cdb_out,
    output complete_t                  complete,
    output logic                       alu_hold,
    output logic                       br_hold,
    output logic                       mul_hold
);

    operands_t  alu_ops;
    operands_t  br_ops;
    operands_t  mul_ops;
    fu_result_t alu_res;
    fu_result_t br_res;
    fu_result_t mul_res;
    logic       mul_grant;

    // ==================================================
    // Operand fetch and bypass per lane
    // ==================================================

    operand_forward #(.cdb_lanes(cdb_lanes)) i_alu_fwd (
        .issue(alu_issue), .cdb_in(cdb_in), .prf_req(alu_prf_req),
        .prf_data(alu_prf_data), .operands(alu_ops)
    );

    operand_forward #(.cdb_lanes(cdb_lanes)) i_br_fwd (
        .issue(br_issue), .cdb_in(cdb_in), .prf_req(br_prf_req),
        .prf_data(br_prf_data), .operands(br_ops)
    );

    operand_forward #(.cdb_lanes(cdb_lanes)) i_mul_fwd (
        .issue(mul_issue), .cdb_in(cdb_in), .prf_req(mul_prf_req),
        .prf_data(mul_prf_data), .operands(mul_ops)
    );

    // Functional units
    alu_unit i_alu (.issue(alu_issue), .operands(alu_ops), .result(alu_res));

    branch_unit i_branch (.issue(br_issue), .operands(br_ops), .result(br_res));

    mult_unit #(.mul_stages(mul_stages)) i_mult (
        .clock(clock), .arst_n(arst_n), .mispredict(mispredict),
        .issue(mul_issue), .operands(mul_ops), .grant(mul_grant),
        .result(mul_res), .hold(mul_hold)
    );

    // Shared result bus
    cdb_arbiter i_arbiter (
        .alu_res(alu_res), .br_res(br_res), .mul_res(mul_res),
        .alu_grant(), .br_grant(), .mul_grant(mul_grant),
        .alu_hold(alu_hold), .br_hold(br_hold),
        .cdb_out(cdb_out), .complete(complete)
    );

endmodule

// ==== logic/mult_unit.sv ====
module mult_unit import exec_pkg::*; #(
    parameter int mul_stages = 3
) (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       mispredict,
    input  issue_t     issue,
    input  operands_t  operands,
    input  logic       grant,
    output fu_result_t result,
    output logic       hold
);

    // Per-stage bookkeeping
    typedef struct packed {
        mul_func_e            func;
        logic [tag_width-1:0] dest;
        logic [rob_width-1:0] rob_idx;
    } mul_meta_t;

    logic [mul_stages-1:0]  stage_valid;
    mul_meta_t              meta [mul_stages];
    logic signed [xlen:0]   op_a;
    logic signed [xlen:0]   op_b;
    logic [2*xlen+1:0]      prod [1:mul_stages-1];
    logic signed [xlen:0]   ext_a;
    logic signed [xlen:0]   ext_b;
    logic                   accept;

    // Last stage offered and lost, freeze everything
    assign hold   = stage_valid[mul_stages-1] & ~grant;
    assign accept = issue.valid & ~hold;

    // Sign or zero extension to 33 bits
    always_comb begin
        ext_a = {(issue.func.mul != mul_mulhu) & operands.src1[xlen-1], operands.src1};
        ext_b = {((issue.func.mul == mul_mul) || (issue.func.mul == mul_mulh))
                 & operands.src2[xlen-1], operands.src2};
    end

    // ==================================================
    // Stage valids
    // ==================================================

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= '0;
        end else if (mispredict) begin
            // Flush all in-flight multiplies
            stage_valid <= '0;
        end else if (!hold) begin
            stage_valid <= {stage_valid[mul_stages-2:0], accept};
        end
    end

    // Payload pipeline
    always_ff @(posedge clock) begin
        if (!hold) begin
            op_a         <= ext_a;
            op_b         <= ext_b;
            meta[0].func    <= issue.func.mul;
            meta[0].dest    <= issue.dest_tag;
            meta[0].rob_idx <= issue.rob_idx;
            // Full product in stage two
            prod[1]      <= (2*xlen+2)'(op_a) * (2*xlen+2)'(op_b);
            for (int i = 1; i < mul_stages; i++) begin
                meta[i] <= meta[i-1];
            end
            for (int i = 2; i < mul_stages; i++) begin
                prod[i] <= prod[i-1];
            end
        end
    end

    // Low word for mul, high word otherwise
    always_comb begin
        result         = '0;
        result.valid   = stage_valid[mul_stages-1];
        result.write   = meta[mul_stages-1].dest != '0;
        result.tag     = meta[mul_stages-1].dest;
        result.rob_idx = meta[mul_stages-1].rob_idx;
        if (meta[mul_stages-1].func == mul_mul) begin
            result.data = prod[mul_stages-1][xlen-1:0];
        end else begin
            result.data = prod[mul_stages-1][2*xlen-1:xlen];
        end
    end

endmodule

// ==== logic/operand_forward.sv ====
module operand_forward import exec_pkg::*; #(
    parameter int cdb_lanes = 2
) (
    input  issue_t                     issue,
    input  cdb_entry_t [cdb_lanes-1:0] cdb_in,
    output prf_req_t                   prf_req,
    input  operands_t                  prf_data,
    output operands_t                  operands
);

    // Register file read request
    always_comb begin
        prf_req.en1  = issue.valid;
        // Second read only for a register operand
        prf_req.en2  = issue.valid & ~issue.opb_is_imm;
        prf_req.tag1 = issue.src1_tag;
        prf_req.tag2 = issue.src2_tag;
    end

    // Broadcast bypass over the register file data
    always_comb begin
        operands = prf_data;
        // Ascending scan, so the highest matching lane wins
        for (int i = 0; i < cdb_lanes; i++) begin
            if (cdb_in[i].valid) begin
                if (cdb_in[i].tag == issue.src1_tag) begin
                    operands.src1 = cdb_in[i].data;
                end
                if (cdb_in[i].tag == issue.src2_tag) begin
                    operands.src2 = cdb_in[i].data;
                end
            end
        end
    end

endmodule

// ==== verif/execute_stage_chk.sv ====
module execute_stage_chk import exec_pkg::*; #(
    parameter int cdb_lanes = 2
) (
    input logic                       clock,
    input logic                       arst_n,
    input issue_t                     alu_issue,
    input issue_t                     br_issue,
    input issue_t                     mul_issue,
    input cdb_entry_t [cdb_lanes-1:0] cdb_in,
    input prf_req_t                   alu_prf_req,
    input prf_req_t                   br_prf_req,
    input prf_req_t                   mul_prf_req,
    input operands_t                  alu_prf_data,
    input operands_t                  br_prf_data,
    input cdb_entry_t                 cdb_out,
    input complete_t                  complete,
    input logic                       alu_hold,
    input logic                       br_hold,
    input logic                       mul_hold
);
    timeunit 1ns;
    timeprecision 100ps;

    int              err_count = 0;
    logic [xlen-1:0] alu_a1;
    logic [xlen-1:0] alu_a2;
    logic [xlen-1:0] br_a1;
    logic [xlen-1:0] br_a2;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu_exp;
    logic            br_taken;
    logic            br_link;
    logic [xlen-1:0] br_target;

    // Latest matching broadcast lane wins
    function automatic logic [xlen-1:0] pick_src(logic [tag_width-1:0] tag,
            logic [xlen-1:0] rf_val, cdb_entry_t [cdb_lanes-1:0] bus);
        logic [xlen-1:0] v;
        v = rf_val;
        for (int i = 0; i < cdb_lanes; i++) begin
            if (bus[i].valid && bus[i].tag == tag) v = bus[i].data;
        end
        return v;
    endfunction

    // Both sources read, second one skipped for an immediate
    function automatic logic req_ok(issue_t it, prf_req_t req);
        return req.en1 == it.valid && (!req.en1 || req.tag1 == it.src1_tag)
            && req.en2 == (it.valid && !it.opb_is_imm)
            && (!req.en2 || req.tag2 == it.src2_tag);
    endfunction

    // ==================================================
    // Reference values per lane
    // ==================================================

    always_comb begin
        alu_a1 = pick_src(alu_issue.src1_tag, alu_prf_data.src1, cdb_in);
        alu_a2 = pick_src(alu_issue.src2_tag, alu_prf_data.src2, cdb_in);
        br_a1  = pick_src(br_issue.src1_tag, br_prf_data.src1, cdb_in);
        br_a2  = pick_src(br_issue.src2_tag, br_prf_data.src2, cdb_in);
        case (alu_issue.opa_sel)
            opa_rs1: opa = alu_a1;
            opa_pc:  opa = alu_issue.pc;
            opa_npc: opa = alu_issue.pc + 32'd4;
            default: opa = '0;
        endcase
        opb = alu_issue.opb_is_imm ? alu_issue.imm : alu_a2;
        case (alu_issue.func.alu)
            alu_add:  alu_exp = opa + opb;
            alu_sub:  alu_exp = opa - opb;
            alu_and:  alu_exp = opa & opb;
            alu_or:   alu_exp = opa | opb;
            alu_xor:  alu_exp = opa ^ opb;
            alu_slt:  alu_exp = {31'd0, $signed(opa) < $signed(opb)};
            alu_sltu: alu_exp = {31'd0, opa < opb};
            alu_sll:  alu_exp = opa << opb[4:0];
            alu_srl:  alu_exp = opa >> opb[4:0];
            alu_sra:  alu_exp = $unsigned($signed(opa) >>> opb[4:0]);
            default:  alu_exp = '0;
        endcase
        br_link = br_issue.func.br inside {br_jal, br_jalr};
        case (br_issue.func.br)
            br_beq:  br_taken = br_a1 == br_a2;
            br_bne:  br_taken = br_a1 != br_a2;
            br_blt:  br_taken = $signed(br_a1) < $signed(br_a2);
            br_bge:  br_taken = !($signed(br_a1) < $signed(br_a2));
            br_bltu: br_taken = br_a1 < br_a2;
            br_bgeu: br_taken = !(br_a1 < br_a2);
            default: br_taken = br_link;
        endcase
        if (br_issue.func.br == br_jalr) begin
            br_target = (br_a1 + br_issue.imm) & 32'hffff_fffe;
        end else begin
            br_target = br_issue.pc + br_issue.imm;
        end
    end

    // ==================================================
    // Port assertions
    // ==================================================

    a_alu: assert property (@(posedge clock) disable iff (!arst_n)
        alu_issue.valid && !alu_hold |-> complete.valid && !complete.branch_valid
        && complete.rob_idx == alu_issue.rob_idx
        && cdb_out.valid == (alu_issue.dest_tag != 0)
        && (!cdb_out.valid
            || (cdb_out.tag == alu_issue.dest_tag && cdb_out.data == alu_exp)))
        else begin err_count++; $error("ALU lane result mismatch"); end

    a_branch: assert property (@(posedge clock) disable iff (!arst_n)
        br_issue.valid && !br_hold |-> complete.valid && complete.branch_valid
        && complete.rob_idx == br_issue.rob_idx && complete.taken == br_taken
        && complete.target == br_target
        && complete.mispredict == (br_taken != br_issue.pred_taken)
        && cdb_out.valid == (br_link && br_issue.dest_tag != 0)
        && (!cdb_out.valid
            || (cdb_out.tag == br_issue.dest_tag && cdb_out.data == br_issue.pc + 32'd4)))
        else begin err_count++; $error("Branch lane result mismatch"); end

    a_prio: assert property (@(posedge clock) disable iff (!arst_n)
        alu_issue.valid && br_issue.valid |-> alu_hold)
        else begin err_count++; $error("ALU won over a valid branch"); end

    a_hold: assert property (@(posedge clock) disable iff (!arst_n)
        (!alu_hold || alu_issue.valid) && (!br_hold || br_issue.valid) && !mul_hold)
        else begin err_count++; $error("Hold raised without a losing offer"); end

    a_req: assert property (@(posedge clock) disable iff (!arst_n)
        req_ok(alu_issue, alu_prf_req) && req_ok(br_issue, br_prf_req)
        && req_ok(mul_issue, mul_prf_req))
        else begin err_count++; $error("Register file request wrong"); end

endmodule

bind execute_stage execute_stage_chk #(.cdb_lanes(cdb_lanes)) i_chk (.*);

// ==== verif/execute_stage_tb.sv ====
module execute_stage_tb import exec_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cdb_lanes   = 2;
    localparam int num_cycles  = 3000;
    localparam int drain_limit = 40;

    // Multiply awaiting its broadcast slot
    typedef struct packed {
        logic [rob_width-1:0] rob_idx;
        logic [tag_width-1:0] dest;
        logic [xlen-1:0]      data;
        int                   due;
    } mul_expect_t;

    logic                       clock;
    logic                       arst_n;
    logic                       mispredict;
    issue_t                     alu_issue;
    issue_t                     br_issue;
    issue_t                     mul_issue;
    cdb_entry_t [cdb_lanes-1:0] cdb_in;
    prf_req_t                   alu_prf_req;
    prf_req_t                   br_prf_req;
    prf_req_t                   mul_prf_req;
    operands_t                  alu_prf_data;
    operands_t                  br_prf_data;
    operands_t                  mul_prf_data;
    cdb_entry_t                 cdb_out;
    complete_t                  complete;
    logic                       alu_hold;
    logic                       br_hold;
    logic                       mul_hold;
    logic                       alu_held;
    logic                       br_held;
    logic [31:0]                rng_state;
    mul_expect_t                expect_q[$];
    int                         waited;

    execute_stage #(.cdb_lanes(cdb_lanes), .mul_stages(3)) i_dut (.*);

    always #4 clock = ~clock;

    // Hold levels as seen by the issue side at the clock edge
    always @(posedge clock) begin
        alu_held <= alu_hold;
        br_held  <= br_hold;
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [xlen-1:0] bypass(logic [tag_width-1:0] tag,
            logic [xlen-1:0] rf_val);
        logic [xlen-1:0] v;
        v = rf_val;
        for (int i = 0; i < cdb_lanes; i++) begin
            if (cdb_in[i].valid && cdb_in[i].tag == tag) v = cdb_in[i].data;
        end
        return v;
    endfunction

    // Low word for mul, high word for the other three
    function automatic logic [xlen-1:0] mul_word(mul_func_e f, logic [xlen-1:0] a,
            logic [xlen-1:0] b);
        logic signed [65:0] p;
        logic               a_signed;
        logic               b_signed;
        a_signed = f != mul_mulhu;
        b_signed = f == mul_mul || f == mul_mulh;
        p = 66'($signed({a_signed & a[31], a})) * 66'($signed({b_signed & b[31], b}));
        return (f == mul_mul) ? p[31:0] : p[63:32];
    endfunction

    function automatic issue_t rand_issue(int func_range, logic imm_ok);
        issue_t      it;
        logic [31:0] r;
        r = next_rand();
        it            = '0;
        it.valid      = r[0] | r[1];
        it.func       = op_func_u'(4'(r[15:8] % func_range));
        it.opa_sel    = opa_sel_e'(r[3:2]);
        it.opb_is_imm = imm_ok & r[4];
        it.pred_taken = r[5];
        it.rob_idx    = r[20:16];
        // Small tag range so broadcasts match often
        it.src1_tag   = {3'd0, r[23:21]};
        it.src2_tag   = {3'd0, r[26:24]};
        it.dest_tag   = {3'd0, r[29:27]};
        it.pc         = next_rand() << 2;
        it.imm        = {{20{r[31]}}, 12'(next_rand() >> 20)};
        return it;
    endfunction

    task automatic fail_value(string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "first error reached");
    endtask

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    // Outputs settled since the last edge
    task automatic check_outputs(int cyc);
        mul_expect_t e;
        if (i_dut.i_chk.err_count != 0) abort_run("A port assertion of the checker fired");
        if (expect_q.size() > 0 && expect_q[0].due == cyc) begin
            e = expect_q.pop_front();
            if (!complete.valid || complete.branch_valid || complete.rob_idx != e.rob_idx)
                fail_value("multiply completion missing or out of order");
            if (cdb_out.valid != (e.dest != 0))
                fail_value("multiply broadcast valid wrong");
            if (cdb_out.valid && (cdb_out.tag != e.dest || cdb_out.data != e.data))
                fail_value("multiply result wrong");
        end else begin
            if (complete.valid != (alu_issue.valid || br_issue.valid))
                fail_value("completion without a matching offer");
            // No multiply result due, so the branch lane has the top slot
            if (br_issue.valid && br_hold)
                fail_value("branch held with no multiply result due");
            if (alu_issue.valid && !br_issue.valid && alu_hold)
                fail_value("ALU held with no competing offer");
        end
    endtask

    task automatic drive_inputs(int cyc, logic active);
        mul_expect_t e;
        if (!alu_held) alu_issue = rand_issue(10, 1'b1);
        if (!br_held) br_issue = rand_issue(8, 1'b0);
        if (!mul_hold) mul_issue = rand_issue(4, 1'b0);
        if (!active) begin
            alu_issue.valid = 1'b0;
            br_issue.valid  = 1'b0;
            mul_issue.valid = 1'b0;
        end
        mispredict   = active && next_rand() % 16 == 0;
        alu_prf_data = {next_rand(), next_rand()};
        br_prf_data  = {next_rand(), next_rand()};
        mul_prf_data = {next_rand(), next_rand()};
        for (int i = 0; i < cdb_lanes; i++) begin
            cdb_in[i] = {next_rand() % 2 == 0, 6'(next_rand() % 8), next_rand()};
        end
        #1;
        if (mispredict) begin
            // Everything in flight is dropped
            expect_q.delete();
        end else if (mul_issue.valid && !mul_hold) begin
            e.rob_idx = mul_issue.rob_idx;
            e.dest    = mul_issue.dest_tag;
            e.data    = mul_word(mul_issue.func.mul,
                                 bypass(mul_issue.src1_tag, mul_prf_data.src1),
                                 bypass(mul_issue.src2_tag, mul_prf_data.src2));
            e.due     = cyc + 3;
            expect_q.push_back(e);
        end
    endtask

    initial begin
        clock        = 1'b0;
        arst_n       = 1'b0;
        mispredict   = 1'b0;
        alu_issue    = '0;
        br_issue     = '0;
        mul_issue    = '0;
        cdb_in       = '0;
        alu_prf_data = '0;
        br_prf_data  = '0;
        mul_prf_data = '0;
        rng_state    = 32'd93011;
        repeat (3) @(negedge clock);
        arst_n = 1'b1;
        for (int k = 0; k < num_cycles; k++) begin
            @(negedge clock);
            check_outputs(k);
            drive_inputs(k, 1'b1);
        end
        // Drain the multiplier with a bounded wait
        waited = 0;
        while (expect_q.size() > 0) begin
            @(negedge clock);
            check_outputs(num_cycles + waited);
            drive_inputs(num_cycles + waited, 1'b0);
            waited++;
            if (waited > drain_limit) abort_run("Timed out waiting for multiply results");
        end
        @(negedge clock);
        if (i_dut.i_chk.err_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "checker reported errors");
        end
    end

endmodule
